// ==== Makefile ====
# Verilator build of the waveform scope testbench.
# Any variable can be overridden, e.g. make run SIM_DIR=build_alt

VERILATOR ?= verilator
TOP       ?= wave_scope_tb
SIM_DIR   ?= sim_build
VFLAGS    ?= --binary --timing --assert -j 0

FILELIST  := project.f
SOURCES   := $(wildcard src/*.sv) $(wildcard verif/*.sv)
SIM_BIN   := $(SIM_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when the file list or a source file changes.
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILELIST)

# The simulator exits non-zero on $fatal, so make fails with the test.
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(SIM_DIR)

// ==== project.f ====
src/wave_scope_pkg.sv
src/wave_capture.sv
src/sample_ram.sv
src/wave_display.sv
src/wave_scope_top.sv
verif/wave_scope_properties.sv
verif/wave_scope_tb.sv

// ==== src/sample_ram.sv ====
`timescale 1ns/1ps

module sample_ram #(
    parameter int ADDR_BITS = 8
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [ADDR_BITS:0]    wr_addr,
    input  wave_scope_pkg::disp_t wr_data,
    input  logic [ADDR_BITS:0]    rd_addr,
    output wave_scope_pkg::disp_t rd_data
);

    import wave_scope_pkg::*;

    localparam int DEPTH = 2 ** (ADDR_BITS + 1);

    // Two halves of 2^ADDR_BITS points, selected by the top address bit.
    disp_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // A read of the address being written returns the old value.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== src/wave_capture.sv ====
`timescale 1ns/1ps

module wave_capture #(
    parameter int ADDR_BITS = 8
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    new_sample,
    input  wave_scope_pkg::sample_t sample,
    input  logic                    display_idle,
    output logic                    wr_en,
    output logic [ADDR_BITS:0]      wr_addr,
    output wave_scope_pkg::disp_t   wr_data,
    output logic                    read_index
);

    import wave_scope_pkg::*;

    capture_state_t       state_q;
    capture_state_t       state_d;
    logic [ADDR_BITS-1:0] count_q;     // Next write position inside the back half.
    logic                 prev_neg_q;  // Sign of the last strobed sample.
    logic                 prev_neg_d;
    logic                 sample_neg;
    logic                 crossing;
    logic                 last_write;

    assign sample_neg = sample[15];
    assign crossing   = prev_neg_q && !sample_neg;

    // Sign as it will stand after this cycle.
    assign prev_neg_d = new_sample ? sample_neg : prev_neg_q;

    // In CAPTURE with nothing written yet the previous sample was negative, so the
    // first write must be the rising crossing itself. After that every strobe is taken.
    assign wr_en = new_sample && (state_q == CAPTURE) && ((count_q != '0) || crossing);

    // The back half is the one the display is not reading.
    assign wr_addr = {~read_index, count_q};

    // Flipping the sign bit of the top byte adds 128.
    assign wr_data = {~sample[15], sample[14:8]};

    assign last_write = wr_en && (count_q == '1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARMED: begin
                if (prev_neg_d) begin
                    state_d = CAPTURE;
                end
            end
            CAPTURE: begin
                if (last_write) begin
                    state_d = HOLD;
                end
            end
            HOLD: begin
                if (display_idle) begin
                    state_d = ARMED;
                end
            end
            default: begin
                state_d = ARMED;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= ARMED;
            count_q    <= '0;
            prev_neg_q <= 1'b0;
            read_index <= 1'b0;
        end else begin
            state_q    <= state_d;
            prev_neg_q <= prev_neg_d;
            if (wr_en) begin
                count_q <= count_q + 1'b1;  // Wraps to zero on the last write.
            end
            if ((state_q == HOLD) && display_idle) begin
                read_index <= ~read_index;  // Show the freshly filled half.
            end
        end
    end

endmodule

// ==== src/wave_display.sv ====
`timescale 1ns/1ps

module wave_display #(
    parameter int ADDR_BITS = 8
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  wave_scope_pkg::pixel_t pix,
    input  logic                   read_index,
    input  wave_scope_pkg::disp_t  rd_data,
    output logic [ADDR_BITS:0]     rd_addr,
    output wave_scope_pkg::rgb_t   rgb
);

    import wave_scope_pkg::*;

    pixel_t   pix_q;     // Pixel aligned with rd_data.
    disp_t    last_q;    // Point under the previous delayed pixel.
    disp_t    prev_q;    // Point at the address before the current one.
    disp_t    prev;
    pixel_y_t row_cur;
    pixel_y_t row_prev;
    pixel_y_t row_top;
    pixel_y_t row_bot;
    logic     in_window;
    logic     on_trace;

    function automatic pixel_y_t point_row(disp_t value);
        disp_t row;
        row = TRACE_ROW_MAX - value;
        return pixel_y_t'(row);
    endfunction

    // Two columns per stored point.
    assign rd_addr = {read_index, pix.x[ADDR_BITS:1]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pix_q <= '0;
        end else begin
            pix_q <= pix;
        end
    end

    // An even column opens a new address, and its predecessor is the point the
    // previous pixel showed. The first column of a line has no predecessor.
    always_comb begin
        if (pix_q.x == '0) begin
            prev = rd_data;
        end else if (!pix_q.x[0]) begin
            prev = last_q;
        end else begin
            prev = prev_q;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_q.valid) begin
            last_q <= rd_data;
            prev_q <= prev;
        end
    end

    assign row_cur  = point_row(rd_data);
    assign row_prev = point_row(prev);
    assign row_top  = (row_cur < row_prev) ? row_cur : row_prev;
    assign row_bot  = (row_cur < row_prev) ? row_prev : row_cur;

    // The vertical segment joins the two points, both ends included.
    assign on_trace  = (pix_q.y >= row_top) && (pix_q.y <= row_bot);
    assign in_window = pix_q.valid && (pix_q.x < WIN_W) && (pix_q.y < WIN_H);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb <= BLACK_RGB;
        end else begin
            rgb <= (in_window && on_trace) ? TRACE_RGB : BLACK_RGB;
        end
    end

endmodule

// ==== src/wave_scope_pkg.sv ====
package wave_scope_pkg;

    // Raw audio input, two's complement.
    typedef logic signed [15:0] sample_t;

    // Top byte of a sample with the sign bit flipped, so 0 is the most negative level.
    typedef logic [7:0] disp_t;

    typedef logic [10:0] pixel_x_t;  // Column 0 to 1279.
    typedef logic [9:0]  pixel_y_t;  // Row 0 to 1023.

    typedef logic [7:0] colour_t;

    typedef struct packed {
        pixel_x_t x;
        pixel_y_t y;
        logic     valid;
    } pixel_t;

    typedef struct packed {
        colour_t r;
        colour_t g;
        colour_t b;
    } rgb_t;

    // The trace window sits in the top left corner of the raster.
    // Each stored point covers two columns, so WIN_W is twice the capture length.
    localparam pixel_x_t WIN_W = 11'd512;
    localparam pixel_y_t WIN_H = 10'd512;

    // A display value v is drawn on row TRACE_ROW_MAX - v.
    localparam disp_t TRACE_ROW_MAX = 8'd255;

    localparam rgb_t TRACE_RGB = '{
        r: 8'h00,
        g: 8'hff,
        b: 8'h00
    };
    localparam rgb_t BLACK_RGB = '0;

    typedef enum logic [1:0] {
        ARMED,    // Waiting for a negative sample.
        CAPTURE,  // Waiting for the crossing, then filling the back half.
        HOLD      // Back half is full and waits for the display to go idle.
    } capture_state_t;

endpackage

// ==== src/wave_scope_top.sv ====
`timescale 1ns/1ps

module wave_scope_top #(
    parameter int ADDR_BITS = 8  // The window holds 2^ADDR_BITS points, two columns each.
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    new_sample,
    input  wave_scope_pkg::sample_t sample,
    input  wave_scope_pkg::pixel_t  pix,
    input  logic                    vsync,
    output wave_scope_pkg::rgb_t    rgb
);

    import wave_scope_pkg::*;

    logic               display_idle;
    logic               read_index;
    logic               wr_en;
    logic [ADDR_BITS:0] wr_addr;
    disp_t              wr_data;
    logic [ADDR_BITS:0] rd_addr;
    disp_t              rd_data;

    // The halves may only swap between frames.
    assign display_idle = ~vsync;

    wave_capture #(
        .ADDR_BITS(ADDR_BITS)
    ) i_capture (
        .clk         (clk),
        .arst_n      (arst_n),
        .new_sample  (new_sample),
        .sample      (sample),
        .display_idle(display_idle),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .read_index  (read_index)
    );

    sample_ram #(
        .ADDR_BITS(ADDR_BITS)
    ) i_ram (
        .clk    (clk),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    wave_display #(
        .ADDR_BITS(ADDR_BITS)
    ) i_display (
        .clk       (clk),
        .arst_n    (arst_n),
        .pix       (pix),
        .read_index(read_index),
        .rd_data   (rd_data),
        .rd_addr   (rd_addr),
        .rgb       (rgb)
    );

endmodule

// ==== verif/wave_scope_properties.sv ====
`timescale 1ns/1ps

module wave_scope_properties (
    input logic                           clk,
    input logic                           arst_n,
    input logic                           vsync,
    input wave_scope_pkg::pixel_t         pix,
    input wave_scope_pkg::rgb_t           rgb,
    input logic                           wr_en,
    input logic                           read_index,
    input wave_scope_pkg::capture_state_t state
);

    import wave_scope_pkg::*;

    // Only a running capture may touch the back half.
    a_wr_in_capture: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> (state == CAPTURE))
        else $error("RAM write strobe outside the CAPTURE state");

    a_swap_in_blank: assert property (@(posedge clk) disable iff (!arst_n)
        (read_index != $past(read_index)) |-> !$past(vsync))
        else $error("read_index toggled while a frame was being scanned");

    a_rgb_legal: assert property (@(posedge clk) disable iff (!arst_n)
        (rgb == TRACE_RGB) || (rgb == BLACK_RGB))
        else $error("rgb is neither the trace colour nor black");

    // The pixel path is two cycles deep.
    a_invalid_black: assert property (@(posedge clk) disable iff (!arst_n)
        !pix.valid |-> ##2 (rgb == BLACK_RGB))
        else $error("rgb not black two cycles after an invalid pixel");

endmodule

// ==== verif/wave_scope_tb.sv ====
`timescale 1ns/1ps

module wave_scope_tb;

    import wave_scope_pkg::*;

    localparam int     ADDR_BITS   = 8;
    localparam int     POINTS      = 2 ** ADDR_BITS;
    localparam int     NUM_FRAMES  = 5;
    localparam longint WATCHDOG_NS = longint'(NUM_FRAMES) * 512 * 520 * 10 + 100_000;

    // One driven pixel together with what rgb has to show for it.
    typedef struct packed {
        pixel_t pix;
        rgb_t   exp;
        logic   chk;
    } probe_t;

    logic    clk;
    logic    arst_n;
    logic    new_sample;
    sample_t sample;
    pixel_t  pix;
    logic    vsync;
    rgb_t    rgb;

    probe_t drv;
    probe_t stage_1;  // Lines up with the DUT's delayed pixel.
    probe_t stage_2;  // Lines up with rgb.

    disp_t back [POINTS];   // Model of the half being filled.
    disp_t shown [POINTS];  // Model of the half on screen.
    logic  shown_ok;
    logic  m_hold;
    logic  m_prev_neg;
    int    m_count;
    int    dut_writes;  // RAM writes the DUT made since reset.

    assign pix = drv.pix;

    wave_scope_top #(
        .ADDR_BITS(ADDR_BITS)
    ) i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .new_sample(new_sample),
        .sample    (sample),
        .pix       (pix),
        .vsync     (vsync),
        .rgb       (rgb)
    );

    bind wave_scope_top wave_scope_properties i_props (
        .clk       (clk),
        .arst_n    (arst_n),
        .vsync     (vsync),
        .pix       (pix),
        .rgb       (rgb),
        .wr_en     (wr_en),
        .read_index(read_index),
        .state     (i_capture.state_q)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    function automatic disp_t to_disp(sample_t s);
        int level;
        level = (int'(s) >>> 8) + 128;  // Top byte moved up by half the range.
        return disp_t'(level);
    endfunction

    function automatic logic in_window(pixel_t p);
        return p.valid && (p.x < WIN_W) && (p.y < WIN_H);
    endfunction

    function automatic rgb_t expected_rgb(pixel_t p);
        int a;
        int row_cur;
        int row_prev;
        int y;
        if (!in_window(p)) begin
            return BLACK_RGB;
        end
        a        = int'(p.x) / 2;
        y        = int'(p.y);
        row_cur  = 255 - int'(shown[a]);
        row_prev = (a == 0) ? row_cur : 255 - int'(shown[a - 1]);
        if ((y >= row_cur && y <= row_prev) || (y >= row_prev && y <= row_cur)) begin
            return TRACE_RGB;
        end
        return BLACK_RGB;
    endfunction

    function automatic sample_t random_negative();
        return sample_t'(-int'($urandom_range(32768, 1)));
    endfunction

    function automatic sample_t random_positive();
        return sample_t'($urandom_range(32767, 0));
    endfunction

    task automatic compare_rgb(string name, rgb_t got, rgb_t want);
        if (got !== want) begin
            $display("Mismatch %s: got %h, expected %h", name, got, want);
            $display("Errors found");
            $fatal(1, "rgb compare failed");
        end
    endtask

    task automatic compare_pixel(string name, pixel_t got, pixel_t want);
        if (got !== want) begin
            $display("Mismatch %s: got %h, expected %h", name, got, want);
            $display("Errors found");
            $fatal(1, "pixel compare failed");
        end
    endtask

    task automatic check_dut(logic cond, string what);
        if (!cond) begin
            $display("DUT behaviour wrong: %s", what);
            $display("Errors found");
            $fatal(1, "DUT check failed");
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_1    <= '0;
            stage_2    <= '0;
            dut_writes <= 0;
        end else begin
            stage_1 <= drv;
            stage_2 <= stage_1;
            if (i_dut.wr_en) begin
                dut_writes <= dut_writes + 1;
            end
        end
    end

    // Outputs only move on rising edges, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (arst_n) begin
            compare_pixel("pix_q", i_dut.i_display.pix_q, stage_1.pix);
            if (stage_2.chk) begin
                compare_rgb("rgb", rgb, stage_2.exp);
            end
        end
    end

    task automatic model_sample(sample_t s);
        logic neg;
        neg = (s < 0);
        if (!m_hold) begin
            if (m_count == 0) begin
                if (m_prev_neg && !neg) begin
                    back[0] = to_disp(s);  // The trigger is the first point.
                    m_count = 1;
                end
            end else begin
                back[m_count] = to_disp(s);
                m_count++;
                if (m_count == POINTS) begin
                    m_hold  = 1'b1;
                    m_count = 0;
                end
            end
        end
        m_prev_neg = neg;
    endtask

    task automatic swap_if_ready();
        if (m_hold && !vsync) begin
            shown    = back;
            shown_ok = 1'b1;
            m_hold   = 1'b0;
        end
    endtask

    task automatic drive_pixel(int x, int y, logic valid);
        pixel_t p;
        p.x     = pixel_x_t'(x);
        p.y     = pixel_y_t'(y);
        p.valid = valid;
        @(negedge clk);
        drv.pix = p;
        drv.exp = expected_rgb(p);
        drv.chk = shown_ok || !in_window(p);
    endtask

    task automatic idle_cycles(int cycles);
        repeat (cycles) begin
            drive_pixel(int'($urandom_range(511, 0)), int'($urandom_range(511, 0)), 1'b0);
            swap_if_ready();
        end
    endtask

    task automatic blank(int cycles);
        vsync = 1'b0;
        idle_cycles(cycles);
        vsync = 1'b1;
    endtask

    // Strobes are three cycles apart, so none falls in the first ARMED cycle.
    task automatic send_sample(sample_t s);
        @(negedge clk);
        new_sample = 1'b1;
        sample     = s;
        model_sample(s);
        swap_if_ready();
        @(negedge clk);
        new_sample = 1'b0;
        @(negedge clk);
    endtask

    task automatic capture_wave();
        int      i;
        sample_t s;
        send_sample(random_negative());
        for (i = 0; i < POINTS; i++) begin
            if (i == 0 || i == POINTS - 1) begin
                s = random_positive();
            end else if (i >= 64 && i < 96) begin
                s = 16'sh1234;  // Flat run.
            end else if (i >= 96 && i < 128) begin
                s = i[0] ? 16'sh7fff : 16'sh8000;  // Full-scale steps.
            end else begin
                s = sample_t'($urandom());
            end
            send_sample(s);
        end
    endtask

    task automatic no_crossing(int count);
        int writes;
        writes = dut_writes;
        repeat (count) send_sample(random_positive());
        repeat (count) send_sample(random_negative());
        check_dut(dut_writes == writes, "the RAM was written without a rising crossing");
    endtask

    task automatic scan_frame();
        int x;
        int y;
        for (y = 0; y < 512; y++) begin
            for (x = 0; x < 520; x++) begin
                if (x < 516) begin
                    drive_pixel(x, y, 1'b1);  // Columns 512 up are right of the window.
                end else if (x < 518) begin
                    drive_pixel((2 * y + x) % 512, y + 512, 1'b1);
                end else begin
                    drive_pixel(int'($urandom_range(511, 0)), y, 1'b0);
                end
            end
        end
        idle_cycles(4);
    endtask

    initial begin
        void'($urandom(32'h6d6b));
        arst_n     = 1'b0;
        new_sample = 1'b0;
        sample     = '0;
        vsync      = 1'b0;
        drv        = '{pix: '0, exp: BLACK_RGB, chk: 1'b1};
        shown_ok   = 1'b0;
        m_hold     = 1'b0;
        m_prev_neg = 1'b0;
        m_count    = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        idle_cycles(8);

        vsync = 1'b1;
        scan_frame();  // Nothing captured yet, so only black pixels are checked.

        vsync = 1'b0;
        capture_wave();
        idle_cycles(8);
        check_dut(i_dut.read_index == 1'b1, "the first capture was not put on display");
        vsync = 1'b1;
        scan_frame();

        blank(8);
        no_crossing(24);
        scan_frame();  // Still the first capture.

        capture_wave();
        check_dut(i_dut.i_capture.state_q == HOLD, "the second capture is not being held");
        scan_frame();  // Held back until the display goes idle.

        blank(8);
        scan_frame();
        idle_cycles(4);
        $display("No errors");
        $finish;
    end

endmodule
